/* design/fir_settings.svh */
// Build-time sizes and register offsets of the symmetric FIR block.
// Taps must be even; only half of the coefficients are stored.

`ifndef FIR_SETTINGS_SVH
`define FIR_SETTINGS_SVH

// filter geometry.
`define FIR_TAPS 8
`define FIR_LANES 4

// sample and coefficient widths, coefficients in Q1.15.
`define FIR_D_BITS 12
`define FIR_M_BITS 16

// ceil((FIR_TAPS-1)/FIR_LANES) beats fill the history.
`define FIR_PRIME_BEATS 2

// APB byte offsets.
`define FIR_ADDR_CTRL 8'h00
`define FIR_ADDR_STATUS 8'h04
`define FIR_ADDR_COEF0 8'h10

`endif

/* design/fir_types_pkg.sv */
// Data types of the symmetric FIR datapath.
// Sample, coefficient, pre-sum, product and accumulator words,
// and the states of the sample window FSM.

`include "fir_settings.svh"

package fir_types_pkg;

    localparam int PRESUM_BITS = `FIR_D_BITS + 1;
    localparam int PROD_BITS   = PRESUM_BITS + `FIR_M_BITS;
    // headroom for the sum of FIR_TAPS/2 products.
    localparam int ACC_BITS    = PROD_BITS + $clog2(`FIR_TAPS / 2);

    typedef logic signed [`FIR_D_BITS-1:0] sample_t;
    typedef logic signed [`FIR_M_BITS-1:0] coef_t;
    typedef logic signed [PRESUM_BITS-1:0] presum_t;
    typedef logic signed [PROD_BITS-1:0]   prod_t;
    typedef logic signed [ACC_BITS-1:0]    acc_t;

    typedef enum logic [1:0] {
        WIN_IDLE  = 2'd0, // no beat since reset or clear.
        WIN_PRIME = 2'd1, // history still filling.
        WIN_RUN   = 2'd2
    } win_state_t;

endpackage

/* design/fir_regmap_pkg.sv */
// Register map of the FIR APB slave.
// Bus word types, control and status field positions,
// and the decoded register select.

package fir_regmap_pkg;

    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // CTRL fields.
    localparam int CTRL_EN_BIT  = 0;
    localparam int CTRL_CLR_BIT = 1; // self-clearing.

    // STATUS fields.
    localparam int STAT_CNT_BITS  = 16;
    localparam int STAT_STATE_LSB = 16;

    typedef enum logic [1:0] {
        REG_CTRL,
        REG_STATUS,
        REG_COEF,
        REG_NONE
    } reg_sel_t;

endpackage

/* design/fir_coef_regs.sv */
// APB register block of the symmetric FIR.
// Holds the coefficient bank and the enable bit, issues a one-cycle
// clear command, and counts output blocks since the last clear.
// No wait states; unmapped addresses and STATUS writes get pslverr.

`include "fir_settings.svh"

module fir_coef_regs (
    input  logic                                   clk_i,
    input  logic                                   rst_n_i,
    input  logic                                   psel_i,
    input  logic                                   penable_i,
    input  logic                                   pwrite_i,
    input  fir_regmap_pkg::apb_addr_t              paddr_i,
    input  fir_regmap_pkg::apb_data_t              pwdata_i,
    input  logic                                   blk_done_i,
    input  fir_types_pkg::win_state_t              win_state_i,
    output fir_regmap_pkg::apb_data_t              prdata_o,
    output logic                                   pready_o,
    output logic                                   pslverr_o,
    output logic                                   enable_o,
    output logic                                   clear_o,
    output fir_types_pkg::coef_t [`FIR_TAPS/2-1:0] coefs_o
);

    localparam int NUM_COEFS = `FIR_TAPS / 2;
    localparam int IDX_BITS  = (NUM_COEFS > 1) ? $clog2(NUM_COEFS) : 1;
    localparam int COEF_END  = `FIR_ADDR_COEF0 + 4 * NUM_COEFS;
    localparam int CNT_BITS  = fir_regmap_pkg::STAT_CNT_BITS;

    fir_regmap_pkg::reg_sel_t             sel;
    fir_regmap_pkg::apb_addr_t            coef_word;
    logic [IDX_BITS-1:0]                  coef_idx;
    logic                                 access;
    logic                                 wr_en;
    logic                                 enable_q;
    logic                                 clear_q;
    logic [CNT_BITS-1:0]                  blk_cnt_q;
    fir_types_pkg::coef_t [NUM_COEFS-1:0] coefs_q;

    assign access    = psel_i & penable_i;
    assign wr_en     = access & pwrite_i;
    assign coef_word = (paddr_i - `FIR_ADDR_COEF0) >> 2;
    assign coef_idx  = coef_word[IDX_BITS-1:0];

    always_comb begin
        if (paddr_i == `FIR_ADDR_CTRL) begin
            sel = fir_regmap_pkg::REG_CTRL;
        end else if (paddr_i == `FIR_ADDR_STATUS) begin
            sel = fir_regmap_pkg::REG_STATUS;
        end else if (paddr_i >= `FIR_ADDR_COEF0 && int'(paddr_i) < COEF_END &&
                     paddr_i[1:0] == 2'b00) begin
            sel = fir_regmap_pkg::REG_COEF;
        end else begin
            sel = fir_regmap_pkg::REG_NONE;
        end
    end

    assign pready_o  = access; // zero wait states.
    assign pslverr_o = access & ((sel == fir_regmap_pkg::REG_NONE) ||
                                 (sel == fir_regmap_pkg::REG_STATUS && pwrite_i));

    always_comb begin
        prdata_o = '0;
        if (access && !pwrite_i) begin
            case (sel)
                fir_regmap_pkg::REG_CTRL:
                    prdata_o[fir_regmap_pkg::CTRL_EN_BIT] = enable_q;
                fir_regmap_pkg::REG_STATUS: begin
                    prdata_o[CNT_BITS-1:0]                     = blk_cnt_q;
                    prdata_o[fir_regmap_pkg::STAT_STATE_LSB +: 2] = win_state_i;
                end
                fir_regmap_pkg::REG_COEF:
                    prdata_o[`FIR_M_BITS-1:0] = coefs_q[coef_idx];
                default:
                    prdata_o = '0;
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            enable_q <= 1'b0;
            clear_q  <= 1'b0;
            coefs_q  <= '0;
        end else begin
            clear_q <= wr_en && sel == fir_regmap_pkg::REG_CTRL &&
                       pwdata_i[fir_regmap_pkg::CTRL_CLR_BIT];
            if (wr_en && sel == fir_regmap_pkg::REG_CTRL) begin
                enable_q <= pwdata_i[fir_regmap_pkg::CTRL_EN_BIT];
            end
            if (wr_en && sel == fir_regmap_pkg::REG_COEF) begin
                coefs_q[coef_idx] <= pwdata_i[`FIR_M_BITS-1:0];
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            blk_cnt_q <= '0;
        end else if (clear_q) begin
            blk_cnt_q <= '0;
        end else if (blk_done_i) begin
            blk_cnt_q <= blk_cnt_q + 1'b1; // wraps at 16 bits.
        end
    end

    assign enable_o = enable_q;
    assign clear_o  = clear_q;
    assign coefs_o  = coefs_q;

endmodule

/* design/fir_sample_window.sv */
// Sliding sample window of the symmetric FIR.
// Accepted beats shift FIR_LANES samples into the tap history; after
// the priming beats each beat registers the newest block together with
// the FIR_TAPS-1 samples before it, index 0 being the oldest.

`include "fir_settings.svh"

module fir_sample_window (
    input  logic                                                 clk_i,
    input  logic                                                 rst_n_i,
    input  logic                                                 enable_i,
    input  logic                                                 clear_i,
    input  logic                                                 data_vld_i,
    input  fir_types_pkg::sample_t [`FIR_LANES-1:0]              data_x_i,
    output logic                                                 win_vld_o,
    output fir_types_pkg::sample_t [`FIR_TAPS-1+`FIR_LANES-1:0]  win_o,
    output fir_types_pkg::win_state_t                            state_o
);

    localparam int HIST_LEN = `FIR_TAPS - 1;
    localparam int WIN_LEN  = HIST_LEN + `FIR_LANES;
    localparam int CNT_BITS = $clog2(`FIR_PRIME_BEATS + 1);

    fir_types_pkg::win_state_t             state_q;
    logic [CNT_BITS-1:0]                   prime_cnt_q;
    logic                                  prime_last;
    logic                                  accept;
    fir_types_pkg::sample_t [HIST_LEN-1:0] hist_q;
    fir_types_pkg::sample_t [WIN_LEN-1:0]  full_win;
    fir_types_pkg::sample_t [WIN_LEN-1:0]  win_q;
    logic                                  win_vld_q;

    assign accept     = data_vld_i & enable_i;
    assign full_win   = {data_x_i, hist_q}; // new block on top.
    assign prime_last = (prime_cnt_q == CNT_BITS'(`FIR_PRIME_BEATS - 1));

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q     <= fir_types_pkg::WIN_IDLE;
            prime_cnt_q <= '0;
            hist_q      <= '0;
        end else if (clear_i) begin
            state_q     <= fir_types_pkg::WIN_IDLE;
            prime_cnt_q <= '0;
            hist_q      <= '0;
        end else if (accept) begin
            hist_q <= full_win[WIN_LEN-1:`FIR_LANES];
            case (state_q)
                fir_types_pkg::WIN_IDLE, fir_types_pkg::WIN_PRIME: begin
                    prime_cnt_q <= prime_cnt_q + 1'b1;
                    state_q     <= prime_last ? fir_types_pkg::WIN_RUN
                                              : fir_types_pkg::WIN_PRIME;
                end
                default:
                    state_q <= fir_types_pkg::WIN_RUN;
            endcase
        end
    end

    // one window per accepted beat once running.
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            win_vld_q <= 1'b0;
        end else begin
            win_vld_q <= accept && !clear_i && state_q == fir_types_pkg::WIN_RUN;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept && state_q == fir_types_pkg::WIN_RUN) begin
            win_q <= full_win;
        end
    end

    assign win_vld_o = win_vld_q;
    assign win_o     = win_q;
    assign state_o   = state_q;

endmodule

/* design/fir_tap_sum.sv */
// Lane-parallel tap stage of the symmetric FIR.
// Cycle one adds each symmetric sample pair and multiplies it by its
// coefficient; cycle two sums the products of a lane, rounds half up,
// drops the Q1.15 fraction and saturates to the sample range.

`include "fir_settings.svh"

module fir_tap_sum (
    input  logic                                                clk_i,
    input  logic                                                rst_n_i,
    input  logic                                                win_vld_i,
    input  fir_types_pkg::sample_t [`FIR_TAPS-1+`FIR_LANES-1:0] win_i,
    input  fir_types_pkg::coef_t [`FIR_TAPS/2-1:0]              coefs_i,
    output logic                                                data_vld_o,
    output fir_types_pkg::sample_t [`FIR_LANES-1:0]             data_y_o
);

    localparam int NUM_COEFS = `FIR_TAPS / 2;
    localparam int LANES     = `FIR_LANES;
    localparam fir_types_pkg::acc_t RND_BIAS =
        fir_types_pkg::acc_t'(1) <<< (`FIR_M_BITS - 2);
    localparam fir_types_pkg::acc_t SAT_MAX =
        fir_types_pkg::acc_t'((1 << (`FIR_D_BITS - 1)) - 1);
    localparam fir_types_pkg::acc_t SAT_MIN =
        fir_types_pkg::acc_t'(-(1 << (`FIR_D_BITS - 1)));

    fir_types_pkg::prod_t                  prod_d [LANES][NUM_COEFS];
    fir_types_pkg::prod_t                  prod_q [LANES][NUM_COEFS];
    fir_types_pkg::sample_t [LANES-1:0]    y_sat;
    logic                                  vld1_q;

    function automatic fir_types_pkg::sample_t round_sat(input fir_types_pkg::acc_t acc);
        fir_types_pkg::acc_t shifted;
        shifted = (acc + RND_BIAS) >>> (`FIR_M_BITS - 1);
        if (shifted > SAT_MAX) begin
            return SAT_MAX[`FIR_D_BITS-1:0];
        end else if (shifted < SAT_MIN) begin
            return SAT_MIN[`FIR_D_BITS-1:0];
        end
        return shifted[`FIR_D_BITS-1:0];
    endfunction

    for (genvar i = 0; i < LANES; i++) begin : g_lane
        for (genvar j = 0; j < NUM_COEFS; j++) begin : g_pair
            fir_types_pkg::sample_t x_old;
            fir_types_pkg::sample_t x_new;
            fir_types_pkg::coef_t   coef;
            fir_types_pkg::presum_t presum;

            assign x_old  = win_i[i + j];
            assign x_new  = win_i[i + `FIR_TAPS - 1 - j]; // mirror tap.
            assign coef   = coefs_i[j];
            assign presum = fir_types_pkg::presum_t'(x_old) + fir_types_pkg::presum_t'(x_new);
            assign prod_d[i][j] = presum * coef;
        end
    end

    // lane sums, then rounding.
    always_comb begin : p_sum
        fir_types_pkg::acc_t acc;
        for (int i = 0; i < LANES; i++) begin
            acc = '0;
            for (int j = 0; j < NUM_COEFS; j++) begin
                acc = acc + fir_types_pkg::acc_t'(prod_q[i][j]);
            end
            y_sat[i] = round_sat(acc);
        end
    end

    always_ff @(posedge clk_i) begin
        if (win_vld_i) begin
            prod_q <= prod_d;
        end
        if (vld1_q) begin
            data_y_o <= y_sat;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            vld1_q     <= 1'b0;
            data_vld_o <= 1'b0;
        end else begin
            vld1_q     <= win_vld_i;
            data_vld_o <= vld1_q;
        end
    end

endmodule

/* design/fir_block_top.sv */
// Top level of the block-parallel symmetric FIR.
// APB register block, sliding sample window and tap-sum stage;
// an accepted beat in run gives a filtered block 3 cycles later.

`include "fir_settings.svh"

module fir_block_top (
    input  logic                                     clk_i,
    input  logic                                     rst_n_i,
    input  logic                                     psel_i,
    input  logic                                     penable_i,
    input  logic                                     pwrite_i,
    input  logic [7:0]                               paddr_i,
    input  logic [31:0]                              pwdata_i,
    output logic [31:0]                              prdata_o,
    output logic                                     pready_o,
    output logic                                     pslverr_o,
    input  logic                                     data_vld_i,
    input  logic [`FIR_LANES-1:0][`FIR_D_BITS-1:0]   data_x_i,
    output logic                                     data_vld_o,
    output logic [`FIR_LANES-1:0][`FIR_D_BITS-1:0]   data_y_o
);

    localparam int WIN_LEN = `FIR_TAPS - 1 + `FIR_LANES;

    logic                                      enable;
    logic                                      clear;
    logic [`FIR_TAPS/2-1:0][`FIR_M_BITS-1:0]   coefs;
    logic                                      win_vld;
    logic [WIN_LEN-1:0][`FIR_D_BITS-1:0]       win;
    fir_types_pkg::win_state_t                 win_state;

    fir_coef_regs i_fir_coef_regs (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .psel_i      (psel_i),
        .penable_i   (penable_i),
        .pwrite_i    (pwrite_i),
        .paddr_i     (paddr_i),
        .pwdata_i    (pwdata_i),
        .blk_done_i  (data_vld_o), // one count per output block.
        .win_state_i (win_state),
        .prdata_o    (prdata_o),
        .pready_o    (pready_o),
        .pslverr_o   (pslverr_o),
        .enable_o    (enable),
        .clear_o     (clear),
        .coefs_o     (coefs)
    );

    fir_sample_window i_fir_sample_window (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .enable_i   (enable),
        .clear_i    (clear),
        .data_vld_i (data_vld_i),
        .data_x_i   (data_x_i),
        .win_vld_o  (win_vld),
        .win_o      (win),
        .state_o    (win_state)
    );

    fir_tap_sum i_fir_tap_sum (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .win_vld_i  (win_vld),
        .win_i      (win),
        .coefs_i    (coefs),
        .data_vld_o (data_vld_o),
        .data_y_o   (data_y_o)
    );

endmodule

/* testbench/fir_block_chk.sv */
// Protocol and latency checks bound into the FIR top level.
// APB access phases, the quiet period after reset and the fixed
// 3-cycle latency from an accepted beat in run to an output block.

module fir_block_chk (
    input logic                      clk_i,
    input logic                      rst_n_i,
    input logic                      psel_i,
    input logic                      penable_i,
    input logic                      pready_i,
    input logic                      pslverr_i,
    input logic                      data_vld_i,
    input logic                      enable_i,
    input logic                      clear_i,
    input fir_types_pkg::win_state_t win_state_i,
    input logic                      y_vld_i
);

    logic run_beat;

    assign run_beat = data_vld_i & enable_i & ~clear_i &
                      (win_state_i == fir_types_pkg::WIN_RUN); // beat that yields a block.

    a_ready_in_access: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        psel_i && penable_i |-> pready_i)
        else $error("pready low during an APB access phase");

    a_slverr_in_access: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        pslverr_i |-> psel_i && penable_i)
        else $error("pslverr raised outside an APB access phase");

    // pipeline must come out of reset empty.
    a_quiet_after_reset: assert property (@(posedge clk_i)
        $rose(rst_n_i) |-> !y_vld_i ##1 !y_vld_i ##1 !y_vld_i)
        else $error("output valid within 3 cycles of reset release");

    a_beat_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        run_beat |-> ##3 y_vld_i)
        else $error("accepted beat in run gave no output block 3 cycles later");

endmodule

bind fir_block_top fir_block_chk i_fir_block_chk (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .psel_i      (psel_i),
    .penable_i   (penable_i),
    .pready_i    (pready_o),
    .pslverr_i   (pslverr_o),
    .data_vld_i  (data_vld_i),
    .enable_i    (enable),
    .clear_i     (clear),
    .win_state_i (win_state),
    .y_vld_i     (data_vld_o)
);

/* testbench/fir_block_tb.sv */
// Testbench for the block-parallel symmetric FIR.
// Programs the APB registers, streams random blocks with random gaps
// and checks every output block against a model of the filter rule.

`include "fir_settings.svh"

module fir_block_tb;

    localparam int LANES       = `FIR_LANES;
    localparam int NUM_COEFS   = `FIR_TAPS / 2;
    localparam int HIST        = `FIR_TAPS - 1;
    localparam int WIN_LEN     = HIST + LANES;
    localparam int S_MAX       = (1 << (`FIR_D_BITS - 1)) - 1;
    localparam int S_MIN       = -(1 << (`FIR_D_BITS - 1));
    localparam int COEF_SPAN   = (1 << `FIR_M_BITS) - 1;
    localparam int NUM_BEATS   = 200;
    localparam int MAX_GAP     = 3;
    localparam int BEATS_ALL   = 280; // every test together, with margin.
    localparam int APB_OPS     = 32;
    localparam int DRAIN_MAX   = 8;
    localparam int STIM_CYCLES = 16 + 4 * APB_OPS + (MAX_GAP + 1) * BEATS_ALL + 8 * DRAIN_MAX;
    localparam int TIMEOUT     = 2 * STIM_CYCLES + 200;

    logic                                   clk_i = 1'b0;
    logic                                   rst_n_i;
    logic                                   psel;
    logic                                   penable;
    logic                                   pwrite;
    logic [7:0]                             paddr;
    logic [31:0]                            pwdata;
    logic [31:0]                            prdata;
    logic                                   pready;
    logic                                   pslverr;
    logic                                   data_vld_in;
    logic [LANES-1:0][`FIR_D_BITS-1:0]      data_x;
    logic                                   data_vld_out;
    logic [LANES-1:0][`FIR_D_BITS-1:0]      data_y;

    string                  test_name;
    int                     model_coef [NUM_COEFS];
    int                     model_hist [HIST];
    int                     prime_cnt;
    bit                     model_en = 1'b0;
    int                     exp_mem [BEATS_ALL][LANES];
    int                     exp_wr = 0;
    int                     since_clear = 0;
    int                     blocks_seen = 0;
    int                     cycle_cnt = 0;
    int                     chk_errs = 0;
    int                     data_errs = 0;
    int                     extra_errs = 0;
    fir_types_pkg::sample_t y_lane;

    fir_block_top i_fir_block_top (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .psel_i     (psel),
        .penable_i  (penable),
        .pwrite_i   (pwrite),
        .paddr_i    (paddr),
        .pwdata_i   (pwdata),
        .prdata_o   (prdata),
        .pready_o   (pready),
        .pslverr_o  (pslverr),
        .data_vld_i (data_vld_in),
        .data_x_i   (data_x),
        .data_vld_o (data_vld_out),
        .data_y_o   (data_y)
    );

    always #2 clk_i = ~clk_i;

    task automatic check_val(input string what, input longint exp_v, input longint act_v);
        assert (exp_v == act_v) else begin
            chk_errs++;
            $display("FAILED %s %s: expected 0x%0h actual 0x%0h", test_name, what, exp_v, act_v);
        end
    endtask

    task automatic apb_access(input logic wr, input fir_regmap_pkg::apb_addr_t addr,
                              input fir_regmap_pkg::apb_data_t wdata,
                              output fir_regmap_pkg::apb_data_t rdata, output logic err);
        @(posedge clk_i);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk_i);
        penable <= 1'b1;
        do begin
            @(negedge clk_i);
        end while (!pready);
        rdata = prdata;
        err   = pslverr;
        @(posedge clk_i);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic write_reg(input fir_regmap_pkg::apb_addr_t addr,
                             input fir_regmap_pkg::apb_data_t data, input logic exp_err);
        fir_regmap_pkg::apb_data_t rd;
        logic                      err;
        apb_access(1'b1, addr, data, rd, err);
        check_val("pslverr on write", longint'(exp_err), longint'(err));
    endtask

    task automatic read_reg(input fir_regmap_pkg::apb_addr_t addr, input logic exp_err,
                            output fir_regmap_pkg::apb_data_t data);
        logic err;
        apb_access(1'b0, addr, 32'h0, data, err);
        check_val("pslverr on read", longint'(exp_err), longint'(err));
    endtask

    task automatic check_status(input int exp_cnt, input fir_types_pkg::win_state_t exp_state);
        fir_regmap_pkg::apb_data_t rd;
        read_reg(`FIR_ADDR_STATUS, 1'b0, rd);
        check_val("block count", longint'(exp_cnt & 'hffff), longint'(rd[15:0]));
        check_val("window state", longint'(exp_state),
                  longint'(rd[fir_regmap_pkg::STAT_STATE_LSB +: 2]));
    endtask

    task automatic program_coefs();
        fir_regmap_pkg::apb_data_t rd;
        for (int j = 0; j < NUM_COEFS; j++) begin
            model_coef[j] = int'($urandom_range(COEF_SPAN, 0)) - (COEF_SPAN + 1) / 2;
            write_reg(fir_regmap_pkg::apb_addr_t'(`FIR_ADDR_COEF0 + 4 * j),
                      fir_regmap_pkg::apb_data_t'(model_coef[j]), 1'b0);
        end
        for (int j = 0; j < NUM_COEFS; j++) begin
            read_reg(fir_regmap_pkg::apb_addr_t'(`FIR_ADDR_COEF0 + 4 * j), 1'b0, rd);
            check_val("coefficient readback", longint'(model_coef[j] & COEF_SPAN), longint'(rd));
        end
    endtask

    task automatic clear_history();
        for (int k = 0; k < HIST; k++) begin
            model_hist[k] = 0;
        end
        prime_cnt   = 0;
        since_clear = 0;
    endtask

    // window index 0 is the oldest sample; taps j and FIR_TAPS-1-j share a coefficient.
    task automatic predict_block(input int x [LANES]);
        int     w [WIN_LEN];
        longint acc;
        for (int k = 0; k < HIST; k++) begin
            w[k] = model_hist[k];
        end
        for (int i = 0; i < LANES; i++) begin
            w[HIST + i] = x[i];
        end
        for (int k = 0; k < HIST; k++) begin
            model_hist[k] = w[k + LANES];
        end
        if (prime_cnt < `FIR_PRIME_BEATS) begin
            prime_cnt++; // history fill only.
        end else begin
            for (int i = 0; i < LANES; i++) begin
                acc = 0;
                for (int j = 0; j < NUM_COEFS; j++) begin
                    acc += longint'(model_coef[j]) * (w[i + j] + w[i + `FIR_TAPS - 1 - j]);
                end
                acc = (acc + (longint'(1) <<< (`FIR_M_BITS - 2))) >>> (`FIR_M_BITS - 1);
                exp_mem[exp_wr][i] = (acc > S_MAX) ? S_MAX : (acc < S_MIN) ? S_MIN : int'(acc);
            end
            exp_wr++;
            since_clear++;
        end
    endtask

    function automatic int rand_sample(input bit full_scale);
        int pick;
        pick = int'($urandom_range(7, 0));
        if (full_scale && pick == 0) begin
            return S_MAX;
        end else if (full_scale && pick == 1) begin
            return S_MIN;
        end
        return int'($urandom_range(S_MAX - S_MIN, 0)) + S_MIN;
    endfunction

    task automatic send_beat(input bit full_scale);
        int x [LANES];
        for (int i = 0; i < LANES; i++) begin
            x[i] = rand_sample(full_scale);
        end
        @(posedge clk_i);
        data_vld_in <= 1'b1;
        for (int i = 0; i < LANES; i++) begin
            data_x[i] <= fir_types_pkg::sample_t'(x[i]);
        end
        if (model_en) begin
            predict_block(x);
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk_i);
            data_vld_in <= 1'b0;
        end
    endtask

    // waits until every predicted block has come out, bounded.
    task automatic drain();
        int waited;
        idle_cycles(1);
        waited = 0;
        while (blocks_seen != exp_wr && waited < DRAIN_MAX) begin
            @(posedge clk_i);
            waited++;
        end
        assert (blocks_seen == exp_wr) else begin
            chk_errs++;
            $display("FAILED %s output blocks: expected %0d actual %0d",
                     test_name, exp_wr, blocks_seen);
        end
    endtask

    task automatic run_stream(input int beats, input int max_gap, input bit full_scale);
        int gap;
        for (int b = 0; b < beats; b++) begin
            send_beat(full_scale);
            gap = 0;
            if (max_gap > 0 && $urandom_range(1, 0) == 1) begin
                gap = int'($urandom_range(max_gap, 1));
            end
            if (gap > 0) begin
                idle_cycles(gap);
            end
        end
        drain();
    endtask

    always @(negedge clk_i) begin
        if (rst_n_i && data_vld_out) begin
            assert (blocks_seen < exp_wr) else begin
                extra_errs++;
                $display("%s: output block %0d has no accepted beat behind it",
                         test_name, blocks_seen);
            end
            if (blocks_seen < exp_wr) begin
                for (int i = 0; i < LANES; i++) begin
                    y_lane = data_y[i];
                    assert (int'(y_lane) == exp_mem[blocks_seen][i]) else begin
                        data_errs++;
                        $display("FAILED %s block %0d lane %0d: expected %0d actual %0d",
                                 test_name, blocks_seen, i, exp_mem[blocks_seen][i], y_lane);
                    end
                end
            end
            blocks_seen++;
        end
    end

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT) begin
            $display("timeout: run stopped after %0d cycles in %s", cycle_cnt, test_name);
            $display("errors: %0d register, %0d data, %0d unexpected block",
                     chk_errs, data_errs, extra_errs);
            $display("sim failed");
            $finish;
        end
    end

    initial begin
        fir_regmap_pkg::apb_data_t rd;
        void'($urandom(24));
        rst_n_i     = 1'b0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        data_vld_in = 1'b0;
        data_x      = '0;
        clear_history();
        test_name = "reset_state";
        repeat (16) @(posedge clk_i);
        rst_n_i <= 1'b1;

        check_status(0, fir_types_pkg::WIN_IDLE);
        run_stream(8, 1, 1'b0); // enable still clear, beats are dropped.
        check_status(0, fir_types_pkg::WIN_IDLE);
        check_val("blocks while disabled", 0, blocks_seen);

        test_name = "register_access";
        read_reg(`FIR_ADDR_CTRL, 1'b0, rd);
        check_val("ctrl after reset", 0, rd);
        program_coefs();
        write_reg(`FIR_ADDR_STATUS, 32'h1, 1'b1);
        read_reg(8'h08, 1'b1, rd);
        write_reg(8'h20, 32'h0, 1'b1); // one word past the last coefficient.

        test_name = "priming";
        write_reg(`FIR_ADDR_CTRL, 32'h1, 1'b0);
        model_en = 1'b1;
        run_stream(`FIR_PRIME_BEATS, 0, 1'b0);
        check_val("blocks during priming", 0, blocks_seen);
        check_status(0, fir_types_pkg::WIN_RUN);
        run_stream(6, 0, 1'b0);
        check_status(6, fir_types_pkg::WIN_RUN);

        test_name = "filter_values";
        run_stream(NUM_BEATS, MAX_GAP, 1'b1);
        check_status(since_clear, fir_types_pkg::WIN_RUN);

        test_name = "clear_and_count";
        write_reg(`FIR_ADDR_CTRL, 32'h3, 1'b0);
        clear_history();
        check_status(0, fir_types_pkg::WIN_IDLE);
        read_reg(`FIR_ADDR_CTRL, 1'b0, rd);
        check_val("ctrl after clear", 1, rd);
        run_stream(12, 2, 1'b1);
        check_status(12 - `FIR_PRIME_BEATS, fir_types_pkg::WIN_RUN);

        test_name = "reprogram";
        write_reg(`FIR_ADDR_CTRL, 32'h0, 1'b0);
        model_en = 1'b0;
        program_coefs();
        write_reg(`FIR_ADDR_CTRL, 32'h1, 1'b0);
        model_en = 1'b1;
        run_stream(40, MAX_GAP, 1'b1);
        check_status(since_clear, fir_types_pkg::WIN_RUN);

        $display("errors: %0d register, %0d data, %0d unexpected block",
                 chk_errs, data_errs, extra_errs);
        if (chk_errs + data_errs + extra_errs == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+design
design/fir_types_pkg.sv
design/fir_regmap_pkg.sv
design/fir_coef_regs.sv
design/fir_sample_window.sv
design/fir_tap_sum.sv
design/fir_block_top.sv
testbench/fir_block_chk.sv
testbench/fir_block_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := fir_block_tb
FILELIST   := sim.f
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert -j 0
OBJ_DIR    := obj_dir
SIM_BIN    := $(OBJ_DIR)/V$(TOP)
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(FILELIST) $(wildcard design/*.sv design/*.svh testbench/*.sv)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# a crash or a failed concurrent assertion also counts as a failing run.
sim: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || echo "sim failed" >> $(LOG)
	@cat $(LOG)
	@if grep -q "sim failed" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
